// ==== src/board_pkg.sv ====
// ------------------------------
// register map, boot states and exit word layout
// the delay defaults assume delays of at least 2 cycles
// ------------------------------
package board_pkg;

  // host register addresses
  localparam logic [2:0] ADDR_ID       = 3'd0;
  localparam logic [2:0] ADDR_SCRATCH  = 3'd1;
  localparam logic [2:0] ADDR_GPIO_OUT = 3'd2;
  localparam logic [2:0] ADDR_GPIO_IN  = 3'd3;
  localparam logic [2:0] ADDR_STATUS   = 3'd4;
  localparam logic [2:0] ADDR_BOOT_GO  = 3'd5;
  localparam logic [2:0] ADDR_EXIT     = 3'd6;

  localparam logic [31:0] SYS_ID = 32'h5E1F_0001;

  // upper half of a valid exit word
  localparam logic [15:0] EXIT_MAGIC = 16'hE0D1;

  // default delays in clock cycles
  localparam int BOOT_DELAY_DEF  = 16;
  localparam int FLASH_DELAY_DEF = 32;
  localparam int LOAD_DELAY_DEF  = 64;

  typedef enum logic [2:0] {
    ST_RESET_WAIT = 3'd0,
    ST_WAIT_HOST  = 3'd1,
    ST_FLASH_BOOT = 3'd2,
    ST_LOAD       = 3'd3,
    ST_RUN        = 3'd4,
    ST_EXITED     = 3'd5
  } boot_state_e;

  typedef struct packed {
    logic [15:0] magic;
    logic [15:0] code;
  } exit_fields_t;

  // raw bit 0 carries the exit value
  typedef union packed {
    logic [31:0]  raw;
    exit_fields_t f;
  } exit_word_u;

endpackage

// ==== src/boot_timer.sv ====
// ------------------------------
// down counter, reloads on load_i and stops at 0
// expired_o stays high at 0 until the next load
// ------------------------------
`timescale 1ns/1ps

module boot_timer #(
  parameter int CNT_W = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             load_i,
  input  logic [CNT_W-1:0] value_i,
  output logic             expired_o
);

  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= value_i;
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // a load in flight masks a stale zero count
  assign expired_o = (count_q == '0) && !load_i;

  a_load_clears_expiry : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (load_i && value_i != '0) |=> !expired_o
  ) else $error("timer expired right after a nonzero load");

endmodule

// ==== src/boot_ctrl.sv ====
// ------------------------------
// boot and exit sequencer; delays must be at least 2
// ST_RESET_WAIT lasts BOOT_DELAY+1 cycles, the timed boots their delay
// ------------------------------
`timescale 1ns/1ps

module boot_ctrl
  import board_pkg::*;
#(
  parameter int BOOT_DELAY  = BOOT_DELAY_DEF,
  parameter int FLASH_DELAY = FLASH_DELAY_DEF,
  parameter int LOAD_DELAY  = LOAD_DELAY_DEF,
  parameter int CNT_W       = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             boot_select_i,
  input  logic             execute_from_flash_i,
  input  logic             boot_go_i,
  input  exit_word_u       exit_word_i,
  input  logic             tmr_expired_i,
  output boot_state_e      state_o,
  output logic             boot_done_o,
  output logic             exit_valid_o,
  output logic             tmr_load_o,
  output logic [CNT_W-1:0] tmr_value_o
);

  boot_state_e      state_q;
  boot_state_e      state_d;
  logic             started_q;
  logic             load_d;
  logic [CNT_W-1:0] value_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_RESET_WAIT: begin
        if (started_q && tmr_expired_i) begin
          if (boot_select_i) begin
            state_d = ST_WAIT_HOST;
          end else if (execute_from_flash_i) begin
            state_d = ST_FLASH_BOOT;
          end else begin
            state_d = ST_LOAD;
          end
        end
      end
      ST_WAIT_HOST: if (boot_go_i) state_d = ST_RUN;
      ST_FLASH_BOOT, ST_LOAD: if (tmr_expired_i) state_d = ST_RUN;
      // exit word may have been parked here long before
      ST_RUN: if (exit_word_i.f.magic == EXIT_MAGIC) state_d = ST_EXITED;
      ST_EXITED: state_d = ST_EXITED;
      default: state_d = ST_RESET_WAIT;
    endcase
  end

  // the count runs 2 cycles short, load pulse and expiry cycle make up the rest
  always_comb begin
    load_d  = 1'b0;
    value_d = tmr_value_o;
    if (!started_q) begin
      load_d  = 1'b1;
      value_d = CNT_W'(BOOT_DELAY - 2);
    end else if (state_d != state_q && state_d == ST_FLASH_BOOT) begin
      load_d  = 1'b1;
      value_d = CNT_W'(FLASH_DELAY - 2);
    end else if (state_d != state_q && state_d == ST_LOAD) begin
      load_d  = 1'b1;
      value_d = CNT_W'(LOAD_DELAY - 2);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ST_RESET_WAIT;
      started_q    <= 1'b0;
      tmr_load_o   <= 1'b0;
      exit_valid_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      started_q    <= 1'b1;
      tmr_load_o   <= load_d;
      exit_valid_o <= (state_d == ST_EXITED);
    end
  end

  always_ff @(posedge clk_i) begin
    tmr_value_o <= value_d;
  end

  assign state_o     = state_q;
  assign boot_done_o = (state_q == ST_RUN) || (state_q == ST_EXITED);

  a_exit_only_when_exited : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    exit_valid_o |-> state_o == ST_EXITED
  ) else $error("exit_valid_o high outside ST_EXITED");

  a_no_load_in_run : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_o == ST_RUN |-> !tmr_load_o
  ) else $error("timer load while running");

endmodule

// ==== src/host_regs.sv ====
// ------------------------------
// host register block, one access per cycle
// read data lands one cycle after host_re_i; GPIO_W up to 32
// ------------------------------
`timescale 1ns/1ps

module host_regs
  import board_pkg::*;
#(
  parameter int GPIO_W = 8
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              host_we_i,
  input  logic              host_re_i,
  input  logic [2:0]        host_addr_i,
  input  logic [31:0]       host_wdata_i,
  output logic [31:0]       host_rdata_o,
  input  logic [GPIO_W-1:0] gpio_i,
  input  boot_state_e       state_i,
  input  logic              boot_done_i,
  output logic              boot_go_o,
  output exit_word_u        exit_word_o,
  output logic [GPIO_W-1:0] gpio_o
);

  logic [31:0]       scratch_q;
  logic [GPIO_W-1:0] gpio_meta_q;
  logic [GPIO_W-1:0] gpio_sync_q;
  logic [31:0]       rdata_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gpio_o      <= '0;
      exit_word_o <= '0;
      boot_go_o   <= 1'b0;
    end else begin
      if (host_we_i && host_addr_i == ADDR_GPIO_OUT) begin
        gpio_o <= host_wdata_i[GPIO_W-1:0];
      end
      if (host_we_i && host_addr_i == ADDR_EXIT) begin
        exit_word_o.raw <= host_wdata_i;
      end
      // single cycle strobe, nothing is stored
      boot_go_o <= host_we_i && (host_addr_i == ADDR_BOOT_GO);
    end
  end

  always_ff @(posedge clk_i) begin
    if (host_we_i && host_addr_i == ADDR_SCRATCH) begin
      scratch_q <= host_wdata_i;
    end
  end

  // two flop sync for the board pins
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gpio_meta_q <= '0;
      gpio_sync_q <= '0;
    end else begin
      gpio_meta_q <= gpio_i;
      gpio_sync_q <= gpio_meta_q;
    end
  end

  always_comb begin
    case (host_addr_i)
      ADDR_ID:       rdata_d = SYS_ID;
      ADDR_SCRATCH:  rdata_d = scratch_q;
      ADDR_GPIO_OUT: rdata_d = 32'(gpio_o);
      ADDR_GPIO_IN:  rdata_d = 32'(gpio_sync_q);
      ADDR_STATUS:   rdata_d = {28'd0, boot_done_i, state_i};
      ADDR_EXIT:     rdata_d = exit_word_o.raw;
      // boot_go and unmapped addresses
      default:       rdata_d = 32'd0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      host_rdata_o <= '0;
    end else if (host_re_i) begin
      host_rdata_o <= rdata_d;
    end
  end

  a_no_read_write_same_cycle : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(host_we_i && host_re_i)
  ) else $error("host read and write in the same cycle");

endmodule

// ==== src/mini_system.sv ====
// ------------------------------
// sequencer, boot timer and host registers
// ------------------------------
`timescale 1ns/1ps

module mini_system
  import board_pkg::*;
#(
  parameter int BOOT_DELAY  = BOOT_DELAY_DEF,
  parameter int FLASH_DELAY = FLASH_DELAY_DEF,
  parameter int LOAD_DELAY  = LOAD_DELAY_DEF,
  parameter int GPIO_W      = 8
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              boot_select_i,
  input  logic              execute_from_flash_i,
  input  logic              host_we_i,
  input  logic              host_re_i,
  input  logic [2:0]        host_addr_i,
  input  logic [31:0]       host_wdata_i,
  output logic [31:0]       host_rdata_o,
  input  logic [GPIO_W-1:0] gpio_i,
  output logic [GPIO_W-1:0] gpio_o,
  output logic              boot_done_o,
  output logic              exit_value_o,
  output logic              exit_valid_o
);

  // counter wide enough for the longest delay
  localparam int MAX_A     = (BOOT_DELAY > FLASH_DELAY) ? BOOT_DELAY : FLASH_DELAY;
  localparam int MAX_DELAY = (MAX_A > LOAD_DELAY) ? MAX_A : LOAD_DELAY;
  localparam int CNT_W     = $clog2(MAX_DELAY + 1);

  logic             boot_go;
  exit_word_u       exit_word;
  boot_state_e      state;
  logic             tmr_load;
  logic [CNT_W-1:0] tmr_value;
  logic             tmr_expired;

  boot_ctrl #(
    .BOOT_DELAY (BOOT_DELAY),
    .FLASH_DELAY(FLASH_DELAY),
    .LOAD_DELAY (LOAD_DELAY),
    .CNT_W      (CNT_W)
  ) u_boot_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_select_i       (boot_select_i),
    .execute_from_flash_i(execute_from_flash_i),
    .boot_go_i           (boot_go),
    .exit_word_i         (exit_word),
    .tmr_expired_i       (tmr_expired),
    .state_o             (state),
    .boot_done_o         (boot_done_o),
    .exit_valid_o        (exit_valid_o),
    .tmr_load_o          (tmr_load),
    .tmr_value_o         (tmr_value)
  );

  boot_timer #(
    .CNT_W(CNT_W)
  ) u_boot_timer (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .load_i   (tmr_load),
    .value_i  (tmr_value),
    .expired_o(tmr_expired)
  );

  host_regs #(
    .GPIO_W(GPIO_W)
  ) u_host_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .host_we_i   (host_we_i),
    .host_re_i   (host_re_i),
    .host_addr_i (host_addr_i),
    .host_wdata_i(host_wdata_i),
    .host_rdata_o(host_rdata_o),
    .gpio_i      (gpio_i),
    .state_i     (state),
    .boot_done_i (boot_done_o),
    .boot_go_o   (boot_go),
    .exit_word_o (exit_word),
    .gpio_o      (gpio_o)
  );

  assign exit_value_o = exit_word.raw[0];

endmodule

// ==== src/board_wrapper.sv ====
// ------------------------------
// board top, rst_i is the active high button
// clk_i drives the design directly, no clock wizard
// ------------------------------
`timescale 1ns/1ps

module board_wrapper
  import board_pkg::*;
#(
  parameter int CLK_LED_COUNT_LENGTH = 27,
  parameter int BOOT_DELAY           = BOOT_DELAY_DEF,
  parameter int FLASH_DELAY          = FLASH_DELAY_DEF,
  parameter int LOAD_DELAY           = LOAD_DELAY_DEF,
  parameter int GPIO_W               = 8
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              boot_select_i,
  input  logic              execute_from_flash_i,
  input  logic              host_we_i,
  input  logic              host_re_i,
  input  logic [2:0]        host_addr_i,
  input  logic [31:0]       host_wdata_i,
  input  logic [GPIO_W-1:0] gpio_i,
  output logic              rst_led_o,
  output logic              clk_led_o,
  output logic              clk_out_o,
  output logic              exit_value_o,
  output logic              exit_valid_o,
  output logic              boot_done_o,
  output logic [31:0]       host_rdata_o,
  output logic [GPIO_W-1:0] gpio_o
);

  logic                            clk_gen;
  logic                            rst_btn_n;
  logic [1:0]                      rst_sync_q;
  logic                            rst_n;
  logic [CLK_LED_COUNT_LENGTH-1:0] clk_count_q;

  assign clk_gen   = clk_i;
  assign rst_btn_n = ~rst_i;

  // async assert, release after two edges
  always_ff @(posedge clk_gen or negedge rst_btn_n) begin
    if (!rst_btn_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign rst_n = rst_sync_q[1];

  // heartbeat
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      clk_count_q <= '0;
    end else begin
      clk_count_q <= clk_count_q + 1'b1;
    end
  end

  assign rst_led_o = rst_n;
  assign clk_led_o = clk_count_q[CLK_LED_COUNT_LENGTH-1];
  assign clk_out_o = clk_gen;

  mini_system #(
    .BOOT_DELAY (BOOT_DELAY),
    .FLASH_DELAY(FLASH_DELAY),
    .LOAD_DELAY (LOAD_DELAY),
    .GPIO_W     (GPIO_W)
  ) u_mini_system (
    .clk_i               (clk_gen),
    .rst_ni              (rst_n),
    .boot_select_i       (boot_select_i),
    .execute_from_flash_i(execute_from_flash_i),
    .host_we_i           (host_we_i),
    .host_re_i           (host_re_i),
    .host_addr_i         (host_addr_i),
    .host_wdata_i        (host_wdata_i),
    .host_rdata_o        (host_rdata_o),
    .gpio_i              (gpio_i),
    .gpio_o              (gpio_o),
    .boot_done_o         (boot_done_o),
    .exit_value_o        (exit_value_o),
    .exit_valid_o        (exit_valid_o)
  );

endmodule

// ==== sim/tb_board_wrapper.sv ====
// ------------------------------
// pattern driven testbench, run from the project root
// reads sim/board_patterns.txt, stops at the first mismatch
// ------------------------------
`timescale 1ns/1ps

module tb_board_wrapper
  import board_pkg::*;
;

  localparam int CLK_LED_LEN = 4;
  localparam int BOOT_DELAY  = 8;
  localparam int FLASH_DELAY = 12;
  localparam int LOAD_DELAY  = 40;
  localparam int GPIO_W      = 8;
  localparam int MAX_LINES   = 64;

  logic              clk_gen;
  logic              rst_i;
  logic              boot_select_i;
  logic              execute_from_flash_i;
  logic              host_we_i;
  logic              host_re_i;
  logic [2:0]        host_addr_i;
  logic [31:0]       host_wdata_i;
  logic [GPIO_W-1:0] gpio_i;
  logic              rst_led_o;
  logic              clk_led_o;
  logic              clk_out_o;
  logic              exit_value_o;
  logic              exit_valid_o;
  logic              boot_done_o;
  logic [31:0]       host_rdata_o;
  logic [GPIO_W-1:0] gpio_o;

  logic [31:0] pat_mem [0:4*MAX_LINES-1];
  integer      seed;
  int          n_lines;
  int          cycles;
  int          cycle_limit;
  int          led_gap;
  int          led_toggles;
  logic        led_seen;
  logic        led_prev;

  board_wrapper #(
    .CLK_LED_COUNT_LENGTH(CLK_LED_LEN),
    .BOOT_DELAY          (BOOT_DELAY),
    .FLASH_DELAY         (FLASH_DELAY),
    .LOAD_DELAY          (LOAD_DELAY),
    .GPIO_W              (GPIO_W)
  ) DUT (
    .clk_i               (clk_gen),
    .rst_i               (rst_i),
    .boot_select_i       (boot_select_i),
    .execute_from_flash_i(execute_from_flash_i),
    .host_we_i           (host_we_i),
    .host_re_i           (host_re_i),
    .host_addr_i         (host_addr_i),
    .host_wdata_i        (host_wdata_i),
    .gpio_i              (gpio_i),
    .rst_led_o           (rst_led_o),
    .clk_led_o           (clk_led_o),
    .clk_out_o           (clk_out_o),
    .exit_value_o        (exit_value_o),
    .exit_valid_o        (exit_valid_o),
    .boot_done_o         (boot_done_o),
    .host_rdata_o        (host_rdata_o),
    .gpio_o              (gpio_o)
  );

  initial begin
    clk_gen = 1'b0;
    forever #10 clk_gen = ~clk_gen;
  end

  // gpio loopback on the falling edge
  always @(negedge clk_gen) begin
    gpio_i <= gpio_o;
  end

  task automatic fail_run();
    $display("Test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      fail_run();
    end
  endtask

  always @(posedge clk_gen) begin
    cycles = cycles + 1;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("timeout: patterns did not finish within %0d cycles", cycle_limit);
      fail_run();
    end
  end

  // clk_out_o mirrors the clock, sampled mid phase
  always @(clk_gen) begin
    #5;
    check_value("clk_out_o", clk_out_o, clk_gen);
  end

  // heartbeat period, sampled before each edge updates the counter
  always @(posedge clk_gen) begin
    if (rst_led_o !== 1'b1) begin
      led_seen = 1'b0;
      led_gap  = 0;
    end else begin
      led_gap = led_gap + 1;
      if (clk_led_o !== led_prev) begin
        if (led_seen) begin
          check_value("clk_led_o period", led_gap, 2 ** (CLK_LED_LEN - 1));
        end
        led_seen    = 1'b1;
        led_gap     = 0;
        led_toggles = led_toggles + 1;
      end
    end
    led_prev = clk_led_o;
  end

  task automatic host_write(input logic [2:0] addr, input logic [31:0] data);
    @(negedge clk_gen);
    host_we_i    = 1'b1;
    host_addr_i  = addr;
    host_wdata_i = data;
    @(negedge clk_gen);
    host_we_i = 1'b0;
  endtask

  task automatic host_read(input logic [2:0] addr, output logic [31:0] data);
    @(negedge clk_gen);
    host_re_i   = 1'b1;
    host_addr_i = addr;
    @(negedge clk_gen);
    host_re_i = 1'b0;
    data      = host_rdata_o;
  endtask

  // straps bit 0 is boot_select, bit 1 execute_from_flash
  task automatic apply_reset(input logic [31:0] straps);
    @(negedge clk_gen);
    rst_i                = 1'b1;
    boot_select_i        = straps[0];
    execute_from_flash_i = straps[1];
    repeat (16) begin
      @(negedge clk_gen);
      check_value("rst_led_o", rst_led_o, 0);
    end
    rst_i = 1'b0;
    repeat (3) @(negedge clk_gen);
    check_value("rst_led_o", rst_led_o, 1);
    check_value("boot_done_o", boot_done_o, 0);
    check_value("exit_valid_o", exit_valid_o, 0);
    check_value("gpio_o", gpio_o, 0);
  endtask

  task automatic check_outputs(input logic [31:0] exp);
    @(negedge clk_gen);
    check_value("exit_valid_o", exit_valid_o, exp[0]);
    // exit value only carries meaning once the exit is valid
    if (exp[0]) begin
      check_value("exit_value_o", exit_value_o, exp[1]);
    end
    check_value("boot_done_o", boot_done_o, exp[2]);
    check_value("gpio_o", gpio_o, exp[15:8]);
  endtask

  task automatic scratch_loop(input int count);
    logic [31:0] val;
    logic [31:0] got;
    for (int i = 0; i < count; i++) begin
      val = $random(seed);
      host_write(ADDR_SCRATCH, val);
      host_read(ADDR_SCRATCH, got);
      check_value("scratch readback", got, val);
    end
  endtask

  task automatic run_line(input int idx);
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
    logic [31:0] got;
    op   = pat_mem[4*idx];
    addr = pat_mem[4*idx+1];
    data = pat_mem[4*idx+2];
    exp  = pat_mem[4*idx+3];
    case (op)
      0: apply_reset(data);
      1: host_write(addr[2:0], data);
      2: begin
        host_read(addr[2:0], got);
        check_value($sformatf("host_rdata_o at address %0d", addr), got, exp);
      end
      3: begin
        while (boot_done_o !== 1'b1) @(negedge clk_gen);
      end
      4: check_outputs(exp);
      5: scratch_loop(data);
      6: repeat (data) @(negedge clk_gen);
      default: begin
        $display("pattern line %0d has an unknown op %h", idx, op);
        fail_run();
      end
    endcase
  endtask

  initial begin
    rst_i                = 1'b1;
    boot_select_i        = 1'b0;
    execute_from_flash_i = 1'b0;
    host_we_i            = 1'b0;
    host_re_i            = 1'b0;
    host_addr_i          = '0;
    host_wdata_i         = '0;
    gpio_i               = '0;
    seed                 = 32'hce85_ffd7;
    cycles               = 0;
    cycle_limit          = 0;
    led_gap              = 0;
    led_toggles          = 0;
    led_seen             = 1'b0;
    led_prev             = 1'b0;
    $readmemh("sim/board_patterns.txt", pat_mem);
    n_lines = 0;
    while (n_lines < MAX_LINES && !$isunknown(pat_mem[4*n_lines]) &&
           pat_mem[4*n_lines] != 32'hf) begin
      n_lines++;
    end
    if (n_lines == 0) begin
      $display("no pattern lines could be read from sim/board_patterns.txt");
      fail_run();
    end
    cycle_limit = n_lines * (LOAD_DELAY + BOOT_DELAY + 20);
    for (int i = 0; i < n_lines; i++) begin
      run_line(i);
    end
    check_value("clk_led_o toggles seen", led_toggles >= 2, 1);
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== sim/board_patterns.txt ====
// op addr data expected, hex; ops 0 reset (data 1 boot_select, 2 flash), 1 write, 2 read
// 3 wait boot_done, 4 outputs (exp 1 valid, 2 value, 4 done, 15:8 gpio), 5 scratch, 6 idle, f end
0 0 00000000 00000000
2 0 00000000 5E1F0001
2 7 00000000 00000000
5 0 00000008 00000000
1 2 000000A5 00000000
2 2 00000000 000000A5
4 0 00000000 0000A500
6 0 00000004 00000000
2 3 00000000 000000A5
3 0 00000000 00000000
2 4 00000000 0000000C
1 6 12340001 00000000
6 0 00000002 00000000
4 0 00000000 0000A504
1 6 E0D10001 00000000
6 0 00000002 00000000
4 0 00000000 0000A507
2 4 00000000 0000000D
0 0 00000002 00000000
3 0 00000000 00000000
2 4 00000000 0000000C
4 0 00000000 00000004
0 0 00000001 00000000
6 0 0000000C 00000000
2 4 00000000 00000001
1 6 E0D10000 00000000
6 0 00000010 00000000
4 0 00000000 00000000
1 5 00000000 00000000
3 0 00000000 00000000
4 0 00000000 00000005
2 4 00000000 0000000D
2 5 00000000 00000000
2 6 00000000 E0D10000
f 0 00000000 00000000

// ==== src.f ====
src/board_pkg.sv
src/boot_timer.sv
src/boot_ctrl.sv
src/host_regs.sv
src/mini_system.sv
src/board_wrapper.sv
sim/tb_board_wrapper.sv
